//--- compile.f
verilog/rv_pkg.sv
verilog/reg_port_if.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_control.sv
verilog/rv_core.sv
tb/tb_mem.sv
tb/tb_core_assert.sv
tb/tb_core.sv

//--- tb/tb_core.sv
// testbench for the rv32i core, runs a table of small programs and checks output and halt
`timescale 1ns/10ps

module tb_core;

    localparam logic [31:0] out_addr   = 32'd1000;
    localparam logic [31:0] halt_addr  = 32'd1004;
    localparam int          wait_limit = 600;

    typedef enum {
        t_add, t_sub, t_and, t_or, t_xor, t_sll, t_srl, t_sra, t_slt, t_sltu,
        t_addi, t_lui, t_auipc, t_ldst,
        t_beq, t_bne, t_blt, t_bge, t_bltu, t_bgeu,
        t_x0, t_bad
    } test_e;

    typedef struct {
        test_e       kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp;
    } row_t;

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic [31:0] mem_rd_data;
    logic        mem_ack;
    logic [31:0] out_data;
    logic        out_valid;
    logic        halt;

    row_t rows[$];
    int   errors;
    int   failed_tests;
    int   out_count;
    int   pc_w;

    rv_core #(
        .reset_pc  (32'd0),
        .out_addr  (out_addr),
        .halt_addr (halt_addr)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    tb_mem mem (
        .clk         (clk),
        .rst         (rst),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack)
    );

    bind rv_control tb_core_assert u_assert (
        .clk        (clk),
        .rst        (rst),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .mem_ack    (mem_ack),
        .out_valid  (out_valid),
        .halt       (halt)
    );

    always #10 clk = ~clk;

    // output strobes seen since the last reset
    always @(negedge clk) begin
        if (rst) begin
            out_count <= 0;
        end else if (out_valid) begin
            out_count <= out_count + 1;
        end
    end

    // rv32i encodings, r-type always computes x3 = x1 op x2
    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] off, logic [4:0] rs2,
                                           logic [4:0] rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    task automatic emit(logic [31:0] word);
        mem.write_word(pc_w, word);
        pc_w += 4;
    endtask

    // lui takes the rounded upper part so the signed addi lands on v
    task automatic load_const(logic [4:0] rd, logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit({hi[31:12], rd, 7'h37});
        emit(i_type(v[11:0], rd, 3'd0, rd, 7'h13));
    endtask

    // taken path skips the 0x11 marker and sets x3 to 0x22
    task automatic emit_branch(logic [2:0] f3);
        emit(b_type(13'd12, 5'd2, 5'd1, f3));
        emit(i_type(12'h011, 5'd0, 3'd0, 5'd3, 7'h13));
        emit(b_type(13'd8, 5'd0, 5'd0, 3'd0));
        emit(i_type(12'h022, 5'd0, 3'd0, 5'd3, 7'h13));
    endtask

    task automatic build_program(row_t r);
        logic [4:0] out_reg;
        out_reg = 5'd3;
        pc_w = 0;
        mem.clear();
        load_const(5'd1, r.a);
        load_const(5'd2, r.b);
        case (r.kind)
            t_add:   emit(r_type(7'h00, 3'd0));
            t_sub:   emit(r_type(7'h20, 3'd0));
            t_sll:   emit(r_type(7'h00, 3'd1));
            t_slt:   emit(r_type(7'h00, 3'd2));
            t_sltu:  emit(r_type(7'h00, 3'd3));
            t_xor:   emit(r_type(7'h00, 3'd4));
            t_srl:   emit(r_type(7'h00, 3'd5));
            t_sra:   emit(r_type(7'h20, 3'd5));
            t_or:    emit(r_type(7'h00, 3'd6));
            t_and:   emit(r_type(7'h00, 3'd7));
            t_addi:  emit(i_type(r.b[11:0], 5'd1, 3'd0, 5'd3, 7'h13));
            t_lui:   emit({r.b[31:12], 5'd3, 7'h37});
            t_auipc: emit({r.b[31:12], 5'd3, 7'h17});
            t_ldst: begin
                // store a at address b, then load it back into x3
                emit(s_type(12'd0, 5'd1, 5'd2));
                emit(i_type(12'd0, 5'd2, 3'd2, 5'd3, 7'h03));
            end
            t_beq:   emit_branch(3'd0);
            t_bne:   emit_branch(3'd1);
            t_blt:   emit_branch(3'd4);
            t_bge:   emit_branch(3'd5);
            t_bltu:  emit_branch(3'd6);
            t_bgeu:  emit_branch(3'd7);
            t_x0: begin
                emit(i_type(12'd5, 5'd1, 3'd0, 5'd0, 7'h13));
                out_reg = 5'd0;
            end
            default: emit(32'h0000_007f);
        endcase
        emit(s_type(out_addr[11:0], out_reg, 5'd0));
        emit(s_type(halt_addr[11:0], 5'd0, 5'd0));
    endtask

    task automatic add_row(test_e kind, logic [31:0] a, logic [31:0] b, logic [31:0] exp);
        row_t r;
        r.kind = kind;
        r.a = a;
        r.b = b;
        r.exp = exp;
        rows.push_back(r);
    endtask

    task automatic fill_table();
        add_row(t_add,   32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
        add_row(t_sub,   32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
        add_row(t_and,   32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200);
        add_row(t_or,    32'hf000_000f, 32'h0f00_00f0, 32'hff00_00ff);
        add_row(t_xor,   32'haaaa_5555, 32'hffff_0000, 32'h5555_5555);
        add_row(t_sll,   32'h0000_0003, 32'h0000_0021, 32'h0000_0006);
        add_row(t_srl,   32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
        add_row(t_sra,   32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
        add_row(t_slt,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        add_row(t_sltu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
        add_row(t_addi,  32'h0000_000a, 32'hffff_fffb, 32'h0000_0005);
        add_row(t_lui,   32'h0000_0000, 32'habcd_e000, 32'habcd_e000);
        // tested instruction sits at pc 16
        add_row(t_auipc, 32'h0000_0000, 32'h0000_1000, 32'h0000_1010);
        add_row(t_ldst,  32'hdead_beef, 32'h0000_0200, 32'hdead_beef);
        add_row(t_beq,   32'h0000_0005, 32'h0000_0005, 32'h0000_0022);
        add_row(t_beq,   32'h0000_0005, 32'h0000_0006, 32'h0000_0011);
        add_row(t_bne,   32'h0000_0005, 32'h0000_0005, 32'h0000_0011);
        add_row(t_bne,   32'h0000_0005, 32'h0000_0006, 32'h0000_0022);
        add_row(t_blt,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0022);
        add_row(t_blt,   32'h0000_0001, 32'hffff_ffff, 32'h0000_0011);
        add_row(t_bge,   32'hffff_ffff, 32'h0000_0001, 32'h0000_0011);
        add_row(t_bge,   32'h0000_0001, 32'hffff_ffff, 32'h0000_0022);
        add_row(t_bltu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0011);
        add_row(t_bltu,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0022);
        add_row(t_bgeu,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0022);
        add_row(t_bgeu,  32'h0000_0001, 32'hffff_ffff, 32'h0000_0011);
        add_row(t_x0,    32'h0000_0007, 32'h0000_0000, 32'h0000_0000);
        add_row(t_bad,   32'h0000_0000, 32'h0000_0000, 32'h0000_0000);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(int idx, row_t r);
        int errors_at_start;
        bit seen;
        errors_at_start = errors;
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        build_program(r);
        repeat (9) @(posedge clk);
        rst <= 1'b0;
        if (r.kind != t_bad) begin
            seen = 1'b0;
            for (int n = 0; n < wait_limit && !seen; n++) begin
                @(negedge clk);
                seen = out_valid;
            end
            if (seen) begin
                check_value("out_data", out_data, r.exp);
            end else begin
                $display("test %0d timed out waiting for the output strobe", idx);
                errors++;
            end
        end
        seen = 1'b0;
        for (int n = 0; n < wait_limit && !seen; n++) begin
            @(negedge clk);
            seen = halt;
        end
        if (!seen) begin
            $display("test %0d timed out waiting for halt", idx);
            errors++;
        end else begin
            // a halted core stays halted and silent on the memory port
            repeat (20) begin
                @(negedge clk);
                check_value("halt", halt, 32'd1);
                check_value("mem_rd_req", mem_rd_req, 32'd0);
                check_value("mem_wr_req", mem_wr_req, 32'd0);
            end
        end
        check_value("out_count", out_count, (r.kind == t_bad) ? 32'd0 : 32'd1);
        if (r.kind == t_ldst) begin
            check_value("mem word", mem.read_word(r.b), r.a);
        end
        if (errors != errors_at_start) begin
            failed_tests++;
        end
        $display("test %0d %s: %s", idx, r.kind.name(),
                 (errors == errors_at_start) ? "ok" : "error");
    endtask

    initial begin
        int total;
        clk = 1'b0;
        rst = 1'b1;
        errors = 0;
        failed_tests = 0;
        fill_table();
        foreach (rows[i]) begin
            run_test(i, rows[i]);
        end
        total = errors + dut.u_control.u_assert.fail_count;
        $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
                 rows.size(), failed_tests, errors, dut.u_control.u_assert.fail_count);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb/tb_core_assert.sv
// bound checks on the core's memory strobes, output strobe and halt
`timescale 1ns/10ps

module tb_core_assert (
    input logic clk,
    input logic rst,
    input logic mem_rd_req,
    input logic mem_wr_req,
    input logic mem_ack,
    input logic out_valid,
    input logic halt
);
    int   fail_count = 0;
    logic pending;

    // one access in flight from its strobe until its ack
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (mem_rd_req || mem_wr_req) begin
            pending <= 1'b1;
        end else if (mem_ack) begin
            pending <= 1'b0;
        end
    end

    strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_req))
        else begin
            $error("read and write strobes high in the same cycle");
            fail_count++;
        end

    no_second_access: assert property (@(posedge clk) disable iff (rst)
        (mem_rd_req || mem_wr_req) |-> !pending)
        else begin
            $error("strobe raised while an access awaits its ack");
            fail_count++;
        end

    out_single_cycle: assert property (@(posedge clk) disable iff (rst)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid high for more than one cycle");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt)
        else begin
            $error("halt dropped without a reset");
            fail_count++;
        end

    quiet_when_halted: assert property (@(posedge clk) disable iff (rst)
        halt |-> !(mem_rd_req || mem_wr_req))
        else begin
            $error("memory strobe raised while halted");
            fail_count++;
        end

endmodule

//--- tb/tb_mem.sv
// behavioral word memory for the testbench, acks each access after a random delay
`timescale 1ns/10ps

module tb_mem #(
    parameter int depth = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wr_data,
    input  logic        mem_rd_req,
    input  logic        mem_wr_req,
    output logic [31:0] mem_rd_data,
    output logic        mem_ack
);
    localparam int aw = $clog2(depth);

    logic [31:0]   words [depth];
    integer        seed = 42252;
    int            left;
    logic          busy;
    logic          is_read;
    logic [aw-1:0] idx;

    // an all-zero word decodes as an unknown opcode, so a stray fetch halts the core
    task automatic clear();
        foreach (words[i]) begin
            words[i] = '0;
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        words[addr[aw+1:2]] = data;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return words[addr[aw+1:2]];
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            busy = 1'b0;
            left = 0;
            mem_ack <= 1'b0;
            mem_rd_data <= '0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_rd_req || mem_wr_req) begin
                busy = 1'b1;
                is_read = mem_rd_req;
                idx = mem_addr[aw+1:2];
                // ack lands 1 to 4 cycles after the strobe
                left = 1 + ($unsigned($random(seed)) % 4);
                if (mem_wr_req) begin
                    words[idx] = mem_wr_data;
                end
            end
            if (busy) begin
                left = left - 1;
                if (left == 0) begin
                    busy = 1'b0;
                    mem_ack <= 1'b1;
                    if (is_read) begin
                        mem_rd_data <= words[idx];
                    end
                end
            end
        end
    end

endmodule

//--- verilog/reg_port_if.sv
// register file port bundle with two combinational reads and one clocked write
`timescale 1ns/10ps

interface reg_port_if;
    import rv_pkg::*;

    logic [reg_sel_w-1:0] rs1_sel;
    logic [reg_sel_w-1:0] rs2_sel;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;

    // write lands on the clock edge where wr_en is high
    logic                 wr_en;
    logic [reg_sel_w-1:0] wr_sel;
    logic [xlen-1:0]      wr_data;

    modport regfile (
        input  rs1_sel, rs2_sel, wr_en, wr_sel, wr_data,
        output rs1_data, rs2_data
    );

    modport reader (
        output rs1_sel, rs2_sel,
        input  rs1_data, rs2_data
    );

    modport writer (
        output wr_en, wr_sel, wr_data
    );

endinterface

//--- verilog/rv_control.sv
// rv32i control FSM sequencing fetch, execute and memory wait, with pc and instruction register
`timescale 1ns/10ps

module rv_control #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_pkg::exec_kind_e           kind,
    input  logic [rv_pkg::xlen-1:0]      result,
    input  logic [rv_pkg::reg_sel_w-1:0] rd_sel,
    input  logic [rv_pkg::xlen-1:0]      next_pc,
    input  logic [rv_pkg::xlen-1:0]      mem_addr_in,
    input  logic [rv_pkg::xlen-1:0]      store_data,
    output logic [rv_pkg::xlen-1:0]      instr,
    output logic [rv_pkg::xlen-1:0]      pc,
    reg_port_if.writer                   rf,
    output logic [rv_pkg::xlen-1:0]      mem_addr,
    output logic [rv_pkg::xlen-1:0]      mem_wr_data,
    output logic                         mem_rd_req,
    output logic                         mem_wr_req,
    input  logic [rv_pkg::xlen-1:0]      mem_rd_data,
    input  logic                         mem_ack,
    output logic [rv_pkg::xlen-1:0]      out_data,
    output logic                         out_valid,
    output logic                         halt
);
    import rv_pkg::*;

    state_e state;
    state_e state_n;
    logic   pc_load;
    logic   exec_write;
    logic   load_done;

    always_comb begin
        state_n = state;
        pc_load = 1'b0;
        case (state)
            st_fetch: begin
                // strobe is high for the whole st_fetch cycle, except the first one after reset
                if (mem_rd_req) begin
                    state_n = st_fetch_wait;
                end
            end
            st_fetch_wait: begin
                if (mem_ack) begin
                    state_n = st_exec;
                end
            end
            st_exec: begin
                case (kind)
                    kind_load, kind_store: state_n = st_mem_wait;
                    kind_halt:             state_n = st_halted;
                    default: begin
                        state_n = st_fetch;
                        pc_load = 1'b1;
                    end
                endcase
            end
            st_mem_wait: begin
                if (mem_ack) begin
                    state_n = st_fetch;
                    pc_load = 1'b1;
                end
            end
            st_halted: state_n = st_halted;
            default:   state_n = st_halted;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_fetch;
            pc         <= reset_pc;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
        end else begin
            state <= state_n;
            // strobes are registered, so each one appears in the first cycle of its state
            mem_rd_req <= (state_n == st_fetch) || (state == st_exec && kind == kind_load);
            mem_wr_req <= state == st_exec && kind == kind_store;
            if (pc_load) begin
                pc <= next_pc;
            end
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == st_fetch_wait && mem_ack) begin
            instr <= mem_rd_data;
        end
    end

    // register writeback from the ALU or from a load
    assign exec_write = state == st_exec && kind == kind_write;
    assign load_done  = state == st_mem_wait && mem_ack && kind == kind_load;

    assign rf.wr_en   = exec_write || load_done;
    assign rf.wr_sel  = rd_sel;
    assign rf.wr_data = (state == st_mem_wait) ? mem_rd_data : result;

    // instruction register holds during a data access, so execute outputs stay valid
    assign mem_addr    = (state == st_fetch) ? pc : mem_addr_in;
    assign mem_wr_data = store_data;

    assign out_data  = store_data;
    assign out_valid = state == st_exec && kind == kind_out;
    assign halt      = state == st_halted;

endmodule

//--- verilog/rv_core.sv
// rv32i multi-cycle core top level with an external memory port, output strobe and halt
`timescale 1ns/10ps

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc  = '0,
    parameter logic [rv_pkg::xlen-1:0] out_addr  = 32'd1000,
    parameter logic [rv_pkg::xlen-1:0] halt_addr = 32'd1004
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wr_data,
    output logic                    mem_rd_req,
    output logic                    mem_wr_req,
    input  logic [rv_pkg::xlen-1:0] mem_rd_data,
    input  logic                    mem_ack,
    output logic [rv_pkg::xlen-1:0] out_data,
    output logic                    out_valid,
    output logic                    halt
);
    import rv_pkg::*;

    exec_kind_e           kind;
    logic [xlen-1:0]      result;
    logic [reg_sel_w-1:0] rd_sel;
    logic [xlen-1:0]      next_pc;
    logic [xlen-1:0]      ex_mem_addr;
    logic [xlen-1:0]      store_data;
    logic [xlen-1:0]      instr;
    logic [xlen-1:0]      pc;

    reg_port_if rf_bus ();

    rv_regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .rf  (rf_bus.regfile)
    );

    rv_execute #(
        .out_addr  (out_addr),
        .halt_addr (halt_addr)
    ) u_execute (
        .instr      (instr),
        .pc         (pc),
        .rf         (rf_bus.reader),
        .kind       (kind),
        .result     (result),
        .rd_sel     (rd_sel),
        .next_pc    (next_pc),
        .mem_addr   (ex_mem_addr),
        .store_data (store_data)
    );

    rv_control #(
        .reset_pc (reset_pc)
    ) u_control (
        .clk         (clk),
        .rst         (rst),
        .kind        (kind),
        .result      (result),
        .rd_sel      (rd_sel),
        .next_pc     (next_pc),
        .mem_addr_in (ex_mem_addr),
        .store_data  (store_data),
        .instr       (instr),
        .pc          (pc),
        .rf          (rf_bus.writer),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

endmodule

//--- verilog/rv_execute.sv
// rv32i execute stage, decodes the instruction register and computes results, branches and addresses
`timescale 1ns/10ps

module rv_execute #(
    parameter logic [rv_pkg::xlen-1:0] out_addr  = 32'd1000,
    parameter logic [rv_pkg::xlen-1:0] halt_addr = 32'd1004
) (
    input  logic [rv_pkg::xlen-1:0]      instr,
    input  logic [rv_pkg::xlen-1:0]      pc,
    reg_port_if.reader                   rf,
    output rv_pkg::exec_kind_e           kind,
    output logic [rv_pkg::xlen-1:0]      result,
    output logic [rv_pkg::reg_sel_w-1:0] rd_sel,
    output logic [rv_pkg::xlen-1:0]      next_pc,
    output logic [rv_pkg::xlen-1:0]      mem_addr,
    output logic [rv_pkg::xlen-1:0]      store_data
);
    import rv_pkg::*;

    opcode_e           opcode;
    logic [funct3_w-1:0] funct3;
    alu_funct_e        alu_funct;
    logic [xlen-1:0]   rs1;
    logic [xlen-1:0]   rs2;
    logic [xlen-1:0]   imm_i;
    logic [xlen-1:0]   imm_s;
    logic [xlen-1:0]   imm_b;
    logic [xlen-1:0]   imm_u;
    logic [xlen-1:0]   alu_out;
    logic              alu_valid;
    logic              taken;
    logic [xlen-1:0]   store_addr;

    // instruction fields
    assign opcode    = opcode_e'(instr[opcode_w-1:0]);
    assign funct3    = instr[funct3_lsb +: funct3_w];
    assign alu_funct = alu_funct_e'({instr[funct7_lsb +: funct7_w], funct3});
    assign rd_sel    = instr[rd_lsb +: reg_sel_w];

    assign rf.rs1_sel = instr[rs1_lsb +: reg_sel_w];
    assign rf.rs2_sel = instr[rs2_lsb +: reg_sel_w];
    assign rs1 = rf.rs1_data;
    assign rs2 = rf.rs2_data;

    // sign-extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    assign store_addr = rs1 + imm_s;
    assign store_data = rs2;

    always_comb begin
        alu_valid = 1'b1;
        case (alu_funct)
            alu_add:  alu_out = rs1 + rs2;
            alu_sub:  alu_out = rs1 - rs2;
            alu_sll:  alu_out = rs1 << rs2[shamt_w-1:0];
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(rs1) < $signed(rs2)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, rs1 < rs2};
            alu_xor:  alu_out = rs1 ^ rs2;
            alu_srl:  alu_out = rs1 >> rs2[shamt_w-1:0];
            // arithmetic shift keeps the sign bit
            alu_sra:  alu_out = $unsigned($signed(rs1) >>> rs2[shamt_w-1:0]);
            alu_or:   alu_out = rs1 | rs2;
            alu_and:  alu_out = rs1 & rs2;
            default: begin
                alu_out   = '0;
                alu_valid = 1'b0;
            end
        endcase
    end

    // branch condition, blt and bge signed
    always_comb begin
        case (branch_funct_e'(funct3))
            beq:     taken = rs1 == rs2;
            bne:     taken = rs1 != rs2;
            blt:     taken = $signed(rs1) < $signed(rs2);
            bge:     taken = $signed(rs1) >= $signed(rs2);
            bltu:    taken = rs1 < rs2;
            bgeu:    taken = rs1 >= rs2;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        kind     = kind_nop;
        result   = '0;
        next_pc  = pc + xlen'(4);
        mem_addr = '0;
        case (opcode)
            op_reg: begin
                // unknown funct pairs only advance pc
                if (alu_valid) begin
                    kind   = kind_write;
                    result = alu_out;
                end
            end
            op_imm: begin
                if (imm_funct_e'(funct3) == addi) begin
                    kind   = kind_write;
                    result = rs1 + imm_i;
                end
            end
            op_lui: begin
                kind   = kind_write;
                result = imm_u;
            end
            op_auipc: begin
                kind   = kind_write;
                result = pc + imm_u;
            end
            op_load: begin
                kind     = kind_load;
                mem_addr = rs1 + imm_i;
            end
            op_store: begin
                mem_addr = store_addr;
                // memory-mapped output and halt addresses never reach memory
                if (store_addr == out_addr) begin
                    kind = kind_out;
                end else if (store_addr == halt_addr) begin
                    kind = kind_halt;
                end else begin
                    kind = kind_store;
                end
            end
            op_branch: begin
                kind = kind_branch;
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            default: kind = kind_halt;
        endcase
    end

endmodule

//--- verilog/rv_pkg.sv
// rv32i core package with widths, instruction field positions and the core's enum types
package rv_pkg;

    // data and address width
    localparam int xlen = 32;
    localparam int reg_sel_w = 5;
    localparam int num_regs = 32;
    localparam int shamt_w = 5;

    // fixed field positions inside an instruction word
    localparam int opcode_w = 7;
    localparam int rd_lsb = 7;
    localparam int funct3_lsb = 12;
    localparam int funct3_w = 3;
    localparam int rs1_lsb = 15;
    localparam int rs2_lsb = 20;
    localparam int funct7_lsb = 25;
    localparam int funct7_w = 7;

    // major opcodes
    typedef enum logic [6:0] {
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111
    } opcode_e;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct_e;

    // {funct7, funct3} of the register-register operations
    typedef enum logic [9:0] {
        alu_add  = 10'b0000000_000,
        alu_sub  = 10'b0100000_000,
        alu_sll  = 10'b0000000_001,
        alu_slt  = 10'b0000000_010,
        alu_sltu = 10'b0000000_011,
        alu_xor  = 10'b0000000_100,
        alu_srl  = 10'b0000000_101,
        alu_sra  = 10'b0100000_101,
        alu_or   = 10'b0000000_110,
        alu_and  = 10'b0000000_111
    } alu_funct_e;

    // only addi is supported under op_imm
    typedef enum logic [2:0] {
        addi = 3'b000
    } imm_funct_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_exec,
        st_mem_wait,
        st_halted
    } state_e;

    // instruction class as seen by the control FSM
    typedef enum logic [2:0] {
        kind_write,
        kind_branch,
        kind_load,
        kind_store,
        kind_out,
        kind_halt,
        kind_nop
    } exec_kind_e;

endpackage

//--- verilog/rv_regfile.sv
// rv32i register file, 32 words with x0 tied to zero, two read ports and one write port
`timescale 1ns/10ps

module rv_regfile (
    input  logic       clk,
    input  logic       rst,
    reg_port_if.regfile rf
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    // x0 is cleared on reset and never written afterwards
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wr_en && rf.wr_sel != '0) begin
            regs[rf.wr_sel] <= rf.wr_data;
        end
    end

    // combinational reads
    assign rf.rs1_data = regs[rf.rs1_sel];
    assign rf.rs2_data = regs[rf.rs2_sel];

endmodule
